// File: lsu_pkg.sv
// Shared LSU types: data width, operation and cause enums, arbiter state enum.
`default_nettype none

package lsu_pkg;

    localparam int XLEN = 32;

    // Memory micro-op encodings.
    typedef enum logic [3:0] {
        LSU_LB,
        LSU_LH,
        LSU_LW,
        LSU_LBU,
        LSU_LHU,
        LSU_SB,
        LSU_SH,
        LSU_SW
    } lsu_op_e;

    // Exception causes follow the RISC-V mcause numbering.
    typedef enum logic [4:0] {
        CAUSE_NONE        = 5'd0,
        CAUSE_LD_MISALIGN = 5'd4,
        CAUSE_ST_MISALIGN = 5'd6
    } lsu_cause_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_READ,
        ARB_ACK,
        ARB_RELEASE
    } arb_state_e;

endpackage

`default_nettype wire

// File: data_ram.sv
// Word-addressed data RAM with byte write enables and registered read.
`timescale 1ns/100ps
`default_nettype none

module data_ram #(
    parameter int ADDR_W = 12
) (
    input  logic                        clk_i,
    input  logic                        en_i,
    input  logic                        we_i,
    input  logic [ADDR_W-3:0]           addr_i,
    input  logic [lsu_pkg::XLEN/8-1:0]  be_i,
    input  logic [lsu_pkg::XLEN-1:0]    wdata_i,
    output logic [lsu_pkg::XLEN-1:0]    rdata_o
);
    import lsu_pkg::*;

    localparam int WORDS = 2 ** (ADDR_W - 2);

    logic [XLEN-1:0] mem [WORDS];

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < XLEN / 8; b++) begin
                    if (be_i[b]) mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
            rdata_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

// File: mem_arbiter.sv
// Round-robin arbiter sharing one RAM port between the load unit and store buffer.
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter #(
    parameter int ADDR_W = 12
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        ld_m_req_i,
    input  logic [ADDR_W-3:0]           ld_m_addr_i,
    output logic                        ld_m_ack_o,
    output logic [lsu_pkg::XLEN-1:0]    ld_m_rdata_o,
    input  logic                        sb_m_req_i,
    input  logic [ADDR_W-3:0]           sb_m_addr_i,
    input  logic [lsu_pkg::XLEN/8-1:0]  sb_m_be_i,
    input  logic [lsu_pkg::XLEN-1:0]    sb_m_wdata_i,
    output logic                        sb_m_ack_o,
    output logic                        ram_en_o,
    output logic                        ram_we_o,
    output logic [ADDR_W-3:0]           ram_addr_o,
    output logic [lsu_pkg::XLEN/8-1:0]  ram_be_o,
    output logic [lsu_pkg::XLEN-1:0]    ram_wdata_o,
    input  logic [lsu_pkg::XLEN-1:0]    ram_rdata_i
);
    import lsu_pkg::*;

    arb_state_e state_q;
    logic       gnt_sb_q;
    logic       pick_sb;
    logic       cur_req;

    // On a tie the peer that was not served last wins.
    assign pick_sb = sb_m_req_i && (!ld_m_req_i || !gnt_sb_q);
    assign cur_req = gnt_sb_q ? sb_m_req_i : ld_m_req_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= ARB_IDLE;
            gnt_sb_q <= 1'b0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (ld_m_req_i || sb_m_req_i) begin
                        gnt_sb_q <= pick_sb;
                        state_q  <= ARB_READ;
                    end
                end
                ARB_READ:    state_q <= ARB_ACK;
                ARB_ACK:     if (!cur_req) state_q <= ARB_RELEASE;
                ARB_RELEASE: state_q <= ARB_IDLE;
                default:     state_q <= ARB_IDLE;
            endcase
        end
    end

    assign ram_en_o     = (state_q == ARB_READ);
    assign ram_we_o     = (state_q == ARB_READ) && gnt_sb_q;
    assign ram_addr_o   = gnt_sb_q ? sb_m_addr_i : ld_m_addr_i;
    assign ram_be_o     = sb_m_be_i;
    assign ram_wdata_o  = sb_m_wdata_i;
    assign ld_m_ack_o   = (state_q == ARB_ACK) && !gnt_sb_q;
    assign sb_m_ack_o   = (state_q == ARB_ACK) && gnt_sb_q;
    assign ld_m_rdata_o = ram_rdata_i;

endmodule

`default_nettype wire

// File: store_buffer.sv
// Store buffer: pending-store FIFO, word-match hazard lookup, background drain.
`timescale 1ns/100ps
`default_nettype none

module store_buffer #(
    parameter int ADDR_W   = 12,
    parameter int SB_DEPTH = 4
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        st_req_i,
    input  logic [ADDR_W-1:0]           st_addr_i,
    input  lsu_pkg::lsu_op_e            st_op_i,
    input  logic [lsu_pkg::XLEN-1:0]    st_data_i,
    output logic                        st_ack_o,
    input  logic [ADDR_W-1:0]           chk_addr_i,
    output logic                        hazard_o,
    output logic                        m_req_o,
    output logic [ADDR_W-3:0]           m_addr_o,
    output logic [lsu_pkg::XLEN/8-1:0]  m_be_o,
    output logic [lsu_pkg::XLEN-1:0]    m_wdata_o,
    input  logic                        m_ack_i
);
    import lsu_pkg::*;

    localparam int NB    = XLEN / 8;
    localparam int PTR_W = (SB_DEPTH > 1) ? $clog2(SB_DEPTH) : 1;

    typedef enum logic [1:0] {D_IDLE, D_REQ, D_REL} drain_state_e;

    logic [ADDR_W-3:0] waddr_q [SB_DEPTH];
    logic [NB-1:0]     be_q    [SB_DEPTH];
    logic [XLEN-1:0]   wdata_q [SB_DEPTH];
    logic [SB_DEPTH-1:0] valid_q;
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic              ack_q;
    drain_state_e      drain_q;
    logic              push;
    logic              pop;
    logic [NB-1:0]     new_be;
    logic [XLEN-1:0]   new_wdata;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(SB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Stores are kept as whole-word writes with byte enables.
    always_comb begin
        case (st_op_i)
            LSU_SB:  new_be = NB'(1) << st_addr_i[1:0];
            LSU_SH:  new_be = NB'(3) << st_addr_i[1:0];
            default: new_be = '1;
        endcase
        new_wdata = st_data_i << (8 * st_addr_i[1:0]);
    end

    assign push = st_req_i && !ack_q && !valid_q[wr_ptr_q];
    assign pop  = (drain_q == D_REL) && !m_ack_i;

    // ==============================
    // FIFO control and drain FSM
    // ==============================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q  <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            ack_q    <= 1'b0;
            drain_q  <= D_IDLE;
        end else begin
            if (push) begin
                valid_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q          <= ptr_inc(wr_ptr_q);
                ack_q             <= 1'b1;
            end else if (ack_q && !st_req_i) begin
                ack_q <= 1'b0;
            end
            case (drain_q)
                D_IDLE: if (valid_q[rd_ptr_q]) drain_q <= D_REQ;
                D_REQ:  if (m_ack_i) drain_q <= D_REL;
                D_REL: begin
                    if (pop) begin
                        valid_q[rd_ptr_q] <= 1'b0;
                        rd_ptr_q          <= ptr_inc(rd_ptr_q);
                        drain_q           <= D_IDLE;
                    end
                end
                default: drain_q <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            waddr_q[wr_ptr_q] <= st_addr_i[ADDR_W-1:2];
            be_q[wr_ptr_q]    <= new_be;
            wdata_q[wr_ptr_q] <= new_wdata;
        end
    end

    always_comb begin
        hazard_o = 1'b0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (valid_q[i] && waddr_q[i] == chk_addr_i[ADDR_W-1:2]) hazard_o = 1'b1;
        end
    end

    assign st_ack_o  = ack_q;
    assign m_req_o   = (drain_q == D_REQ);
    assign m_addr_o  = waddr_q[rd_ptr_q];
    assign m_be_o    = be_q[rd_ptr_q];
    assign m_wdata_o = wdata_q[rd_ptr_q];

endmodule

`default_nettype wire

// File: load_unit.sv
// Load engine: hazard wait, RAM read through the arbiter, lane extract and extend.
`timescale 1ns/100ps
`default_nettype none

module load_unit #(
    parameter int ADDR_W = 12
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      ld_req_i,
    input  logic [ADDR_W-1:0]         ld_addr_i,
    input  lsu_pkg::lsu_op_e          ld_op_i,
    output logic                      ld_ack_o,
    output logic [lsu_pkg::XLEN-1:0]  ld_data_o,
    output logic [ADDR_W-1:0]         chk_addr_o,
    input  logic                      hazard_i,
    output logic                      m_req_o,
    output logic [ADDR_W-3:0]         m_addr_o,
    input  logic                      m_ack_i,
    input  logic [lsu_pkg::XLEN-1:0]  m_rdata_i
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {L_IDLE, L_WAIT, L_MEM, L_MREL, L_ACK} load_state_e;

    load_state_e       state_q;
    logic [ADDR_W-1:0] addr_q;
    lsu_op_e           op_q;
    logic [XLEN-1:0]   data_q;

    // Picks the addressed lane out of a RAM word and extends it per the op.
    function automatic logic [XLEN-1:0] extend_lane(input lsu_op_e op, input logic [1:0] off,
                                                    input logic [XLEN-1:0] word);
        logic [7:0]  lane_b;
        logic [15:0] lane_h;
        lane_b = word[8*off +: 8];
        lane_h = word[16*off[1] +: 16];
        case (op)
            LSU_LB:  return {{(XLEN-8){lane_b[7]}}, lane_b};
            LSU_LBU: return {{(XLEN-8){1'b0}}, lane_b};
            LSU_LH:  return {{(XLEN-16){lane_h[15]}}, lane_h};
            LSU_LHU: return {{(XLEN-16){1'b0}}, lane_h};
            default: return word;
        endcase
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= L_IDLE;
        end else begin
            case (state_q)
                L_IDLE: if (ld_req_i) state_q <= L_WAIT;
                // No forwarding, so a matching buffered store must drain first.
                L_WAIT: if (!hazard_i) state_q <= L_MEM;
                L_MEM:  if (m_ack_i) state_q <= L_MREL;
                L_MREL: if (!m_ack_i) state_q <= L_ACK;
                L_ACK:  if (!ld_req_i) state_q <= L_IDLE;
                default: state_q <= L_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == L_IDLE && ld_req_i) begin
            addr_q <= ld_addr_i;
            op_q   <= ld_op_i;
        end
        if (state_q == L_MEM && m_ack_i) begin
            data_q <= extend_lane(op_q, addr_q[1:0], m_rdata_i);
        end
    end

    assign chk_addr_o = addr_q;
    assign m_req_o    = (state_q == L_MEM);
    assign m_addr_o   = addr_q[ADDR_W-1:2];
    assign ld_ack_o   = (state_q == L_ACK);
    assign ld_data_o  = data_q;

endmodule

`default_nettype wire

// File: lsu_issue.sv
// Request front end: handshake, address generation, alignment check, dispatch.
`timescale 1ns/100ps
`default_nettype none

module lsu_issue #(
    parameter int ADDR_W = 12,
    parameter int ROB_W  = 6
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      req_i,
    input  lsu_pkg::lsu_op_e          op_i,
    input  logic [lsu_pkg::XLEN-1:0]  rs1_i,
    input  logic [lsu_pkg::XLEN-1:0]  imm_i,
    input  logic [lsu_pkg::XLEN-1:0]  rs2_i,
    input  logic [ROB_W-1:0]          tag_i,
    output logic                      ack_o,
    output logic [lsu_pkg::XLEN-1:0]  rdata_o,
    output logic [ROB_W-1:0]          tag_o,
    output lsu_pkg::lsu_cause_e       cause_o,
    output logic                      ld_req_o,
    output logic [ADDR_W-1:0]         ld_addr_o,
    output lsu_pkg::lsu_op_e          ld_op_o,
    input  logic                      ld_ack_i,
    input  logic [lsu_pkg::XLEN-1:0]  ld_data_i,
    output logic                      st_req_o,
    output logic [ADDR_W-1:0]         st_addr_o,
    output lsu_pkg::lsu_op_e          st_op_o,
    output logic [lsu_pkg::XLEN-1:0]  st_data_o,
    input  logic                      st_ack_i
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_LOAD, S_STORE, S_SUB_REL, S_ACK} issue_state_e;

    issue_state_e      state_q;
    logic [XLEN-1:0]   eff_addr;
    logic              is_load;
    logic              misaligned;
    logic [ADDR_W-1:0] addr_q;
    lsu_op_e           op_q;
    logic [ROB_W-1:0]  tag_q;
    logic [XLEN-1:0]   data_q;
    logic [XLEN-1:0]   rdata_q;
    lsu_cause_e        cause_q;

    always_comb begin
        eff_addr = rs1_i + imm_i;
        is_load  = op_i inside {LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU};
        case (op_i)
            LSU_LH, LSU_LHU, LSU_SH: misaligned = eff_addr[0];
            LSU_LW, LSU_SW:          misaligned = |eff_addr[1:0];
            default:                 misaligned = 1'b0;
        endcase
    end

    // ==============================
    // Control FSM
    // ==============================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (req_i) begin
                        // A misaligned access is answered here without touching memory.
                        if (misaligned) state_q <= S_ACK;
                        else if (is_load) state_q <= S_LOAD;
                        else state_q <= S_STORE;
                    end
                end
                S_LOAD:    if (ld_ack_i) state_q <= S_SUB_REL;
                S_STORE:   if (st_ack_i) state_q <= S_SUB_REL;
                S_SUB_REL: if (!ld_ack_i && !st_ack_i) state_q <= S_ACK;
                S_ACK:     if (!req_i) state_q <= S_IDLE;
                default:   state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && req_i) begin
            addr_q  <= eff_addr[ADDR_W-1:0];
            op_q    <= op_i;
            tag_q   <= tag_i;
            data_q  <= rs2_i;
            rdata_q <= '0;
            if (!misaligned) cause_q <= CAUSE_NONE;
            else if (is_load) cause_q <= CAUSE_LD_MISALIGN;
            else cause_q <= CAUSE_ST_MISALIGN;
        end else if (state_q == S_LOAD && ld_ack_i) begin
            rdata_q <= ld_data_i;
        end
    end

    assign ack_o     = (state_q == S_ACK);
    assign rdata_o   = rdata_q;
    assign tag_o     = tag_q;
    assign cause_o   = cause_q;
    assign ld_req_o  = (state_q == S_LOAD);
    assign ld_addr_o = addr_q;
    assign ld_op_o   = op_q;
    assign st_req_o  = (state_q == S_STORE);
    assign st_addr_o = addr_q;
    assign st_op_o   = op_q;
    assign st_data_o = data_q;

endmodule

`default_nettype wire

// File: lsu_top.sv
// LSU top level: issue, load unit, store buffer, arbiter and data RAM.
`timescale 1ns/100ps
`default_nettype none

module lsu_top #(
    parameter int ADDR_W   = 12,
    parameter int ROB_W    = 6,
    parameter int SB_DEPTH = 4
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      req_i,
    input  lsu_pkg::lsu_op_e          op_i,
    input  logic [lsu_pkg::XLEN-1:0]  rs1_i,
    input  logic [lsu_pkg::XLEN-1:0]  imm_i,
    input  logic [lsu_pkg::XLEN-1:0]  rs2_i,
    input  logic [ROB_W-1:0]          tag_i,
    output logic                      ack_o,
    output logic [lsu_pkg::XLEN-1:0]  rdata_o,
    output logic [ROB_W-1:0]          tag_o,
    output lsu_pkg::lsu_cause_e       cause_o
);
    import lsu_pkg::*;

    logic              ld_req, ld_ack, st_req, st_ack;
    logic [ADDR_W-1:0] ld_addr, st_addr, chk_addr;
    lsu_op_e           ld_op, st_op;
    logic [XLEN-1:0]   ld_data, st_data;
    logic              hazard;
    logic              ld_m_req, ld_m_ack, sb_m_req, sb_m_ack;
    logic [ADDR_W-3:0] ld_m_addr, sb_m_addr, ram_addr;
    logic [XLEN/8-1:0] sb_m_be, ram_be;
    logic [XLEN-1:0]   sb_m_wdata, ld_m_rdata, ram_wdata, ram_rdata;
    logic              ram_en, ram_we;

    lsu_issue #(.ADDR_W(ADDR_W), .ROB_W(ROB_W)) u_issue (
        .clk_i, .arst_n_i, .req_i, .op_i, .rs1_i, .imm_i, .rs2_i, .tag_i,
        .ack_o, .rdata_o, .tag_o, .cause_o,
        .ld_req_o(ld_req), .ld_addr_o(ld_addr), .ld_op_o(ld_op),
        .ld_ack_i(ld_ack), .ld_data_i(ld_data),
        .st_req_o(st_req), .st_addr_o(st_addr), .st_op_o(st_op),
        .st_data_o(st_data), .st_ack_i(st_ack)
    );

    load_unit #(.ADDR_W(ADDR_W)) u_load (
        .clk_i, .arst_n_i,
        .ld_req_i(ld_req), .ld_addr_i(ld_addr), .ld_op_i(ld_op),
        .ld_ack_o(ld_ack), .ld_data_o(ld_data),
        .chk_addr_o(chk_addr), .hazard_i(hazard),
        .m_req_o(ld_m_req), .m_addr_o(ld_m_addr), .m_ack_i(ld_m_ack), .m_rdata_i(ld_m_rdata)
    );

    store_buffer #(.ADDR_W(ADDR_W), .SB_DEPTH(SB_DEPTH)) u_sb (
        .clk_i, .arst_n_i,
        .st_req_i(st_req), .st_addr_i(st_addr), .st_op_i(st_op),
        .st_data_i(st_data), .st_ack_o(st_ack),
        .chk_addr_i(chk_addr), .hazard_o(hazard),
        .m_req_o(sb_m_req), .m_addr_o(sb_m_addr), .m_be_o(sb_m_be),
        .m_wdata_o(sb_m_wdata), .m_ack_i(sb_m_ack)
    );

    // Port 0 is the load unit, port 1 the store buffer.
    mem_arbiter #(.ADDR_W(ADDR_W)) u_arb (
        .clk_i, .arst_n_i,
        .ld_m_req_i(ld_m_req), .ld_m_addr_i(ld_m_addr),
        .ld_m_ack_o(ld_m_ack), .ld_m_rdata_o(ld_m_rdata),
        .sb_m_req_i(sb_m_req), .sb_m_addr_i(sb_m_addr), .sb_m_be_i(sb_m_be),
        .sb_m_wdata_i(sb_m_wdata), .sb_m_ack_o(sb_m_ack),
        .ram_en_o(ram_en), .ram_we_o(ram_we), .ram_addr_o(ram_addr),
        .ram_be_o(ram_be), .ram_wdata_o(ram_wdata), .ram_rdata_i(ram_rdata)
    );

    data_ram #(.ADDR_W(ADDR_W)) u_ram (
        .clk_i,
        .en_i(ram_en), .we_i(ram_we), .addr_i(ram_addr),
        .be_i(ram_be), .wdata_i(ram_wdata), .rdata_o(ram_rdata)
    );

endmodule

`default_nettype wire

// File: lsu_asserts.sv
// Bound protocol assertions: four-phase handshake rules and exclusive peer acks.
`timescale 1ns/100ps
`default_nettype none

module lsu_asserts (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic req_i,
    input  logic ack_i,
    input  logic ack_a_i,
    input  logic ack_b_i
);
    int unsigned fail_cnt = 0;

    // Only one access is in flight at a time, so the two peer acks never overlap.
    ack_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(ack_a_i && ack_b_i))
        else begin
            $error("two peer acks are high in the same cycle");
            fail_cnt++;
        end

    // The ack answers the req that was sampled on the edge that raised it.
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(ack_i) |-> $past(req_i))
        else begin
            $error("ack rose while req was low");
            fail_cnt++;
        end

    // A new request waits for the previous ack to fall.
    req_after_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(req_i) |-> !ack_i)
        else begin
            $error("req rose while ack was still high");
            fail_cnt++;
        end

endmodule

bind lsu_issue lsu_asserts u_issue_chk (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .req_i(req_i), .ack_i(ack_o),
    .ack_a_i(ld_ack_i), .ack_b_i(st_ack_i)
);

bind mem_arbiter lsu_asserts u_arb_chk (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .req_i(ld_m_req_i), .ack_i(ld_m_ack_o),
    .ack_a_i(ld_m_ack_o), .ack_b_i(sb_m_ack_o)
);

`default_nettype wire

// File: tb_lsu.sv
// LSU testbench: clock, reset, request tasks, reference memory model, compare tasks.
`timescale 1ns/100ps
`default_nettype none

module tb_lsu;
    import lsu_pkg::*;

    localparam int ADDR_W   = 12;
    localparam int ROB_W    = 6;
    localparam int SB_DEPTH = 4;
    localparam int TIMEOUT  = 200;
    localparam int DRV_DLY  = 10;
    localparam int WIN_BASE = 'h500;
    localparam int WIN_SIZE = 64;

    logic              clk;
    logic              arst_n;
    logic              req;
    lsu_op_e           op;
    logic [XLEN-1:0]   rs1;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   rs2;
    logic [ROB_W-1:0]  tag;
    logic              ack;
    logic [XLEN-1:0]   rdata;
    logic [ROB_W-1:0]  tag_out;
    lsu_cause_e        cause;

    // Byte-wide reference memory, indexed by byte address.
    logic [7:0] ref_mem [2**ADDR_W];

    lsu_top UUT (
        .clk_i(clk), .arst_n_i(arst_n), .req_i(req), .op_i(op),
        .rs1_i(rs1), .imm_i(imm), .rs2_i(rs2), .tag_i(tag),
        .ack_o(ack), .rdata_o(rdata), .tag_o(tag_out), .cause_o(cause)
    );

    always #50 clk = ~clk;

    // ==============================
    // Reference model
    // ==============================
    function automatic bit is_load_op(input lsu_op_e op_v);
        return op_v inside {LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU};
    endfunction

    function automatic int access_size(input lsu_op_e op_v);
        case (op_v)
            LSU_LB, LSU_LBU, LSU_SB: return 1;
            LSU_LH, LSU_LHU, LSU_SH: return 2;
            default:                 return 4;
        endcase
    endfunction

    function automatic bit misaligned(input lsu_op_e op_v, input int addr);
        return (addr % access_size(op_v)) != 0;
    endfunction

    // Little-endian gather; LB and LH copy the top loaded bit upward.
    function automatic logic [XLEN-1:0] model_load(input lsu_op_e op_v, input int addr);
        logic [XLEN-1:0] val;
        val = '0;
        for (int i = 0; i < access_size(op_v); i++) val[8*i +: 8] = ref_mem[addr + i];
        if (op_v == LSU_LB && val[7]) val[XLEN-1:8] = '1;
        if (op_v == LSU_LH && val[15]) val[XLEN-1:16] = '1;
        return val;
    endfunction

    function automatic void model_store(input lsu_op_e op_v, input int addr,
                                        input logic [XLEN-1:0] data_v);
        for (int i = 0; i < access_size(op_v); i++) ref_mem[addr + i] = data_v[8*i +: 8];
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) fail_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_tag(input logic [ROB_W-1:0] got, input logic [ROB_W-1:0] exp);
        if (got !== exp) fail_run($sformatf("error: tag_o got 0x%h expected 0x%h", got, exp));
    endtask

    task automatic check_cause(input lsu_cause_e got, input lsu_cause_e exp);
        if (got !== exp) fail_run($sformatf("error: cause_o got 0x%h expected 0x%h", got, exp));
    endtask

    // ==============================
    // Request handshake
    // ==============================
    task automatic do_req(input lsu_op_e op_v, input logic [XLEN-1:0] rs1_v,
                          input logic [XLEN-1:0] imm_v, input logic [XLEN-1:0] rs2_v,
                          input logic [ROB_W-1:0] tag_v, output logic [XLEN-1:0] data_r,
                          output logic [ROB_W-1:0] tag_r, output lsu_cause_e cause_r);
        int cnt;
        op  = op_v;
        rs1 = rs1_v;
        imm = imm_v;
        rs2 = rs2_v;
        tag = tag_v;
        req = 1'b1;
        cnt = 0;
        while (ack !== 1'b1) begin
            if (cnt == TIMEOUT) fail_run("timeout: ack_o never rose for a request");
            @(posedge clk);
            #DRV_DLY;
            cnt++;
        end
        data_r  = rdata;
        tag_r   = tag_out;
        cause_r = cause;
        req     = 1'b0;
        cnt     = 0;
        while (ack !== 1'b0) begin
            if (cnt == TIMEOUT) fail_run("timeout: ack_o stayed high after req_i fell");
            @(posedge clk);
            #DRV_DLY;
            cnt++;
        end
    endtask

    // Issues one op at a byte address and checks the answer against the model.
    task automatic run_op(input lsu_op_e op_v, input int addr, input logic [XLEN-1:0] data_v);
        logic [XLEN-1:0]  imm_v;
        logic [ROB_W-1:0] tag_v;
        logic [XLEN-1:0]  data_r;
        logic [XLEN-1:0]  data_x;
        logic [ROB_W-1:0] tag_r;
        lsu_cause_e       cause_r;
        lsu_cause_e       cause_x;
        imm_v  = $urandom_range(127) - 64;
        tag_v  = ROB_W'($urandom);
        data_x = '0;
        if (misaligned(op_v, addr)) begin
            cause_x = is_load_op(op_v) ? CAUSE_LD_MISALIGN : CAUSE_ST_MISALIGN;
        end else begin
            cause_x = CAUSE_NONE;
            if (is_load_op(op_v)) data_x = model_load(op_v, addr);
        end
        do_req(op_v, XLEN'(addr) - imm_v, imm_v, data_v, tag_v, data_r, tag_r, cause_r);
        check_tag(tag_r, tag_v);
        check_cause(cause_r, cause_x);
        check_data("rdata_o", data_r, data_x);
        if (!is_load_op(op_v) && cause_x == CAUSE_NONE) model_store(op_v, addr, data_v);
    endtask

    task automatic load_all_lanes(input int base);
        for (int off = 0; off < 4; off++) begin
            run_op(LSU_LB, base + off, '0);
            run_op(LSU_LBU, base + off, '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            run_op(LSU_LH, base + off, '0);
            run_op(LSU_LHU, base + off, '0);
        end
        run_op(LSU_LW, base, '0);
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic test_word_round_trip();
        if (ack !== 1'b0) fail_run($sformatf("error: ack_o got 0x%h expected 0x0", ack));
        run_op(LSU_SW, 'h100, 32'hdead_beef);
        run_op(LSU_LW, 'h100, '0);
    endtask

    task automatic test_sub_word();
        run_op(LSU_SW, 'h200, 32'h1122_3344);
        for (int off = 0; off < 4; off++) run_op(LSU_SB, 'h200 + off, 32'h80 | (off * 32'h31));
        load_all_lanes('h200);
        for (int off = 0; off < 4; off += 2) run_op(LSU_SH, 'h200 + off, 32'h8000 + off * 32'h1357);
        load_all_lanes('h200);
    endtask

    task automatic test_misalign();
        run_op(LSU_SW, 'h300, 32'hcafe_f00d);
        run_op(LSU_LH, 'h301, '0);
        run_op(LSU_LHU, 'h303, '0);
        run_op(LSU_SH, 'h301, 32'h0000_5a5a);
        run_op(LSU_LW, 'h302, '0);
        run_op(LSU_SW, 'h301, 32'h1234_5678);
        run_op(LSU_SW, 'h303, 32'h8765_4321);
        run_op(LSU_LW, 'h300, '0);
    endtask

    task automatic test_ordering();
        for (int i = 0; i < SB_DEPTH + 2; i++) begin
            if (i % 2 == 0) run_op(LSU_SW, 'h400, 32'h0101_0101 * (i + 1));
            else run_op(LSU_SB, 'h400 + i % 4, 32'hf0 + i);
        end
        run_op(LSU_LW, 'h400, '0);
    endtask

    task automatic test_random_mix();
        lsu_op_e op_v;
        int      size;
        int      addr;
        for (int w = 0; w < WIN_SIZE; w += 4) run_op(LSU_SW, WIN_BASE + w, $urandom);
        for (int n = 0; n < 200; n++) begin
            op_v = lsu_op_e'($urandom_range(7));
            size = access_size(op_v);
            addr = WIN_BASE + ($urandom_range(WIN_SIZE - 1) / size) * size;
            run_op(op_v, addr, $urandom);
        end
    endtask

    initial begin
        void'($urandom(32'h59e2_0f53));
        clk    = 1'b0;
        arst_n = 1'b0;
        req    = 1'b0;
        op     = LSU_LW;
        rs1    = '0;
        imm    = '0;
        rs2    = '0;
        tag    = '0;
        repeat (10) @(posedge clk);
        #DRV_DLY;
        arst_n = 1'b1;
        test_word_round_trip();
        test_sub_word();
        test_misalign();
        test_ordering();
        test_random_mix();
        if (UUT.u_issue.u_issue_chk.fail_cnt + UUT.u_arb.u_arb_chk.fail_cnt == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_run("protocol assertions reported failures");
        end
    end

endmodule

`default_nettype wire

// File: tb.f
lsu_pkg.sv
data_ram.sv
mem_arbiter.sv
store_buffer.sv
load_unit.sv
lsu_issue.sv
lsu_top.sv
lsu_asserts.sv
tb_lsu.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - data_ram.sv
  - mem_arbiter.sv
  - store_buffer.sv
  - load_unit.sv
  - lsu_issue.sv
  - lsu_top.sv
  - target: test
    files:
      - lsu_asserts.sv
      - tb_lsu.sv
